// File: bus_arb_top.f
source/bus_arb_pkg.sv
source/addr_tenure_if.sv
source/addr_arb_fsm.sv
source/aack_timer.sv
source/data_tenure_queue.sv
source/bus_arb_top.sv
verif/bus_arb_sva.sv
verif/bus_arb_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds and runs the bus arbiter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
	--top-module bus_arb_tb \
	-Mdir obj_dir \
	-f bus_arb_top.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vbus_arb_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// File: verif/bus_arb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arb_tb;

	localparam int DATA_BEATS = 4;
	localparam int TMO = 300;

	logic clk;
	logic rst_n;
	logic br1_n;
	logic br2_n;
	logic ts_n;
	logic artry_n;
	logic ta_n;
	logic bg1_n;
	logic bg2_n;
	logic aack_n;
	logic dbg1_n;
	logic dbg2_n;

	int errors;
	int timeouts;
	// memory model stops all beats while this is set
	bit hold_ta;
	// owners that must get the data bus in this order
	int exp_q[$];
	int grant_order[$];
	int beats;
	int prev_dbg;
	int cur_dbg;

	bus_arb_top dut_i (
		.clk(clk), .rst_n(rst_n), .br1_n(br1_n), .br2_n(br2_n), .ts_n(ts_n),
		.artry_n(artry_n), .ta_n(ta_n), .bg1_n(bg1_n), .bg2_n(bg2_n),
		.aack_n(aack_n), .dbg1_n(dbg1_n), .dbg2_n(dbg2_n)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_val(input string test, input int exp, input int act);
		assert (exp == act) else begin
			errors++;
			$display("** Error %s: expected %0d, actual %0d", test, exp, act);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("timeout while waiting for %s", what);
	endtask

	function automatic logic bg_of(input int m);
		return (m == 1) ? bg1_n : bg2_n;
	endfunction

	task automatic set_br(input int m, input logic v);
		if (m == 1) br1_n = v;
		else br2_n = v;
	endtask

	// waits at falling edges until aack_n is low
	task automatic wait_aack();
		int n;
		n = 0;
		while (aack_n) begin
			@(negedge clk);
			n++;
			if (n > TMO) begin
				report_timeout("aack_n");
				return;
			end
		end
	endtask

	// master model that requests the bus and starts its tenure a cycle after the grant
	// it lets go of the request once acknowledged and plays the snooper in the window
	task automatic do_tenure(input int m, input bit retry);
		int n;
		n = 0;
		set_br(m, 1'b0);
		while (bg_of(m)) begin
			@(negedge clk);
			n++;
			if (n > TMO) begin
				report_timeout("an address grant");
				set_br(m, 1'b1);
				return;
			end
		end
		grant_order.push_back(m);
		@(negedge clk);
		ts_n = 1'b0;
		@(negedge clk);
		ts_n = 1'b1;
		wait_aack();
		set_br(m, 1'b1);
		@(negedge clk);
		if (retry) artry_n = 1'b0;
		else exp_q.push_back(m);
		@(negedge clk);
		artry_n = 1'b1;
	endtask

	// a new ts_n straight after the window and without a request
	task automatic park_tenure(input int m);
		ts_n = 1'b0;
		@(negedge clk);
		ts_n = 1'b1;
		wait_aack();
		@(negedge clk);
		exp_q.push_back(m);
		@(negedge clk);
	endtask

	// waits until every queued tenure has had its data bus
	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 || !dbg1_n || !dbg2_n) begin
			@(negedge clk);
			n++;
			if (n > TMO) begin
				report_timeout("the data queue to drain");
				return;
			end
		end
	endtask

	// memory model with random gaps between transfer acknowledges
	always @(negedge clk) begin
		if ((!dbg1_n || !dbg2_n) && !hold_ta) ta_n <= ($urandom % 3 == 0);
		else ta_n <= 1'b1;
	end

	// data bus monitor that reads the same values the DUT samples
	always @(posedge clk) begin
		if (rst_n) begin
			cur_dbg = !dbg1_n ? 1 : (!dbg2_n ? 2 : 0);
			if (cur_dbg != 0 && prev_dbg == 0) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("data grant given with no tenure waiting");
				end else begin
					check_val("dbg order", exp_q.pop_front(), cur_dbg);
				end
				beats = 0;
			end
			if (cur_dbg == 0 && prev_dbg != 0) check_val("beat count", DATA_BEATS, beats);
			if (cur_dbg != 0 && !ta_n) beats++;
			prev_dbg = cur_dbg;
		end
	end

	initial begin
		void'($urandom(32'h0fdb7178));
		errors = 0;
		timeouts = 0;
		hold_ta = 1'b0;
		beats = 0;
		prev_dbg = 0;
		rst_n = 1'b0;
		br1_n = 1'b1;
		br2_n = 1'b1;
		ts_n = 1'b1;
		artry_n = 1'b1;
		ta_n = 1'b1;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_val("reset bg1_n", 1, bg1_n);
		check_val("reset bg2_n", 1, bg2_n);
		check_val("reset aack_n", 1, aack_n);
		check_val("reset dbg1_n", 1, dbg1_n);
		check_val("reset dbg2_n", 1, dbg2_n);
		// lone request and then a parked tenure of master 1
		do_tenure(1, 1'b0);
		park_tenure(1);
		// master 1 owned the bus last so master 2 wins when both request
		grant_order.delete();
		fork
			do_tenure(1, 1'b0);
			do_tenure(2, 1'b0);
		join
		check_val("alternation from idle1", 2, grant_order[0]);
		// artry_n low in idle holds the grant
		artry_n = 1'b0;
		br2_n = 1'b0;
		repeat (4) begin
			@(negedge clk);
			check_val("retry hold bg2_n", 1, bg2_n);
		end
		artry_n = 1'b1;
		do_tenure(2, 1'b1);
		wait_drain();
		// master 2 owned the bus last so master 1 wins this time
		// and with no beats the two tenures fill the queue
		hold_ta = 1'b1;
		grant_order.delete();
		fork
			do_tenure(1, 1'b0);
			do_tenure(2, 1'b0);
		join
		check_val("alternation from idle2", 1, grant_order[0]);
		br1_n = 1'b0;
		repeat (6) begin
			@(negedge clk);
			check_val("full queue bg1_n", 1, bg1_n);
		end
		hold_ta = 1'b0;
		do_tenure(1, 1'b0);
		wait_drain();
		repeat (4) @(negedge clk);
		$display("value errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/bus_arb_sva.sv
`timescale 1ns/1ps
`default_nettype none

// timing rules of the arbiter, seen from the top level ports and from the
// start and full events inside the design
module bus_arb_sva #(
	parameter int AACK_DELAY = 2
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic br1_n,
	input wire logic br2_n,
	input wire logic ts_n,
	input wire logic artry_n,
	input wire logic bg1_n,
	input wire logic bg2_n,
	input wire logic aack_n,
	input wire logic dbg1_n,
	input wire logic dbg2_n,
	input wire logic start,
	input wire logic full
);

	// reset leaves every grant and the acknowledge released
	reset_released: assert property (@(posedge clk)
		!rst_n |=> (bg1_n && bg2_n && aack_n && dbg1_n && dbg2_n))
		else $error("outputs not released after reset");

	// only one master owns the address bus
	bg_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(!bg1_n && !bg2_n))
		else $error("both address grants low");

	// only one master owns the data bus
	dbg_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(!dbg1_n && !dbg2_n))
		else $error("both data grants low");

	// the acknowledge is a single cycle pulse
	aack_single: assert property (@(posedge clk) disable iff (!rst_n)
		!aack_n |=> aack_n)
		else $error("aack_n low for more than one cycle");

	// start comes one edge after ts_n, so aack_n is seen AACK_DELAY edges later
	aack_delay: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> ##AACK_DELAY !aack_n ##1 aack_n)
		else $error("aack_n not at the fixed delay after ts_n");

	// a snooper holding artry_n low in idle keeps both grants off
	retry_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(!artry_n && bg1_n && bg2_n) |=> (bg1_n && bg2_n))
		else $error("address grant given while artry_n low");

	// a lone request from idle is granted on the next edge
	lone_request1: assert property (@(posedge clk) disable iff (!rst_n)
		(bg1_n && bg2_n && artry_n && !full && ts_n && !br1_n && br2_n) |=> !bg1_n)
		else $error("lone request of master 1 not granted");

	lone_request2: assert property (@(posedge clk) disable iff (!rst_n)
		(bg1_n && bg2_n && artry_n && !full && ts_n && br1_n && !br2_n) |=> !bg2_n)
		else $error("lone request of master 2 not granted");

endmodule

bind bus_arb_top bus_arb_sva #(
	.AACK_DELAY (AACK_DELAY)
) sva_i (
	.clk     (clk),
	.rst_n   (rst_n),
	.br1_n   (br1_n),
	.br2_n   (br2_n),
	.ts_n    (ts_n),
	.artry_n (artry_n),
	.bg1_n   (bg1_n),
	.bg2_n   (bg2_n),
	.aack_n  (aack_n),
	.dbg1_n  (dbg1_n),
	.dbg2_n  (dbg2_n),
	.start   (tenure_if.start),
	.full    (tenure_if.full)
);

`default_nettype wire

// File: source/bus_arb_top.sv
`timescale 1ns/1ps
`default_nettype none

// two-master bus arbiter
// the fsm owns the address bus grants, the timer acknowledges each address
// tenure, and the queue hands out the data bus in tenure order
module bus_arb_top import bus_arb_pkg::*; #(
	parameter aack_dly_t AACK_DELAY = 3'd2,
	parameter beat_cnt_t DATA_BEATS = 4'd4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic br1_n,
	input  logic br2_n,
	input  logic ts_n,
	input  logic artry_n,
	input  logic ta_n,
	output logic bg1_n,
	output logic bg2_n,
	output logic aack_n,
	output logic dbg1_n,
	output logic dbg2_n
);

	// address tenure events shared by the three blocks
	addr_tenure_if tenure_if ();

	// artry_n goes to the fsm to hold grants in idle
	addr_arb_fsm fsm_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.br1_n   (br1_n),
		.br2_n   (br2_n),
		.ts_n    (ts_n),
		.artry_n (artry_n),
		.bg1_n   (bg1_n),
		.bg2_n   (bg2_n),
		.tenure  (tenure_if)
	);

	aack_timer #(
		.AACK_DELAY (AACK_DELAY)
	) timer_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.aack_n (aack_n),
		.tenure (tenure_if)
	);

	// artry_n also decides in the window whether a tenure is queued
	data_tenure_queue #(
		.DATA_BEATS (DATA_BEATS)
	) queue_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.artry_n (artry_n),
		.ta_n    (ta_n),
		.dbg1_n  (dbg1_n),
		.dbg2_n  (dbg2_n),
		.tenure  (tenure_if)
	);

endmodule

`default_nettype wire

// File: source/data_tenure_queue.sv
`timescale 1ns/1ps
`default_nettype none

// in-order data bus grant
// tenures that pass the retry window are queued by owner and get the data bus
// one at a time, each for DATA_BEATS transfer acknowledges
module data_tenure_queue import bus_arb_pkg::*; #(
	parameter beat_cnt_t DATA_BEATS = 4'd4
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         artry_n,
	input  logic         ta_n,
	output logic         dbg1_n,
	output logic         dbg2_n,
	addr_tenure_if.queue tenure
);

	// owner of the tenure in its address phase
	cpu_id_e   pend_owner;
	cpu_id_e   fifo_mem [0:1];
	logic      wr_ptr;
	logic      rd_ptr;
	logic [1:0] count;
	cpu_id_e   head;
	// the head entry holds the data bus
	logic      busy;
	beat_cnt_t beat_cnt;
	logic      push;
	logic      pop;
	logic      grant;

	assign head = fifo_mem[rd_ptr];

	// a tenure retried in its window never reaches the data bus
	assign push = tenure.window && artry_n;

	// the data bus is only granted when it is free
	assign grant = !busy && count != 2'd0;

	// the last beat releases the data bus and frees the entry
	assign pop = busy && !ta_n && beat_cnt == DATA_BEATS - 4'd1;

	// the entry in its data phase still counts, which keeps the address
	// phase of the next tenure from overrunning the queue
	assign tenure.full = count == 2'd2;

	always_ff @(posedge clk) begin
		if (tenure.start) begin
			pend_owner <= tenure.owner;
		end
		if (push) begin
			fifo_mem[wr_ptr] <= pend_owner;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr   <= 1'b0;
			rd_ptr   <= 1'b0;
			count    <= 2'd0;
			busy     <= 1'b0;
			beat_cnt <= '0;
			dbg1_n   <= 1'b1;
			dbg2_n   <= 1'b1;
		end else begin
			if (push) begin
				wr_ptr <= ~wr_ptr;
			end
			if (pop) begin
				rd_ptr <= ~rd_ptr;
			end
			case ({push, pop})
				2'b10: count <= count + 2'd1;
				2'b01: count <= count - 2'd1;
				default: count <= count;
			endcase
			// beats are only counted while a grant is out, and a high ta_n
			// holds both the count and the grant
			if (grant) begin
				busy     <= 1'b1;
				beat_cnt <= '0;
				dbg1_n   <= head != CPU1;
				dbg2_n   <= head != CPU2;
			end else if (pop) begin
				busy     <= 1'b0;
				beat_cnt <= '0;
				dbg1_n   <= 1'b1;
				dbg2_n   <= 1'b1;
			end else if (busy && !ta_n) begin
				beat_cnt <= beat_cnt + 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/aack_timer.sv
`timescale 1ns/1ps
`default_nettype none

// address acknowledge timer
// aack follows the accepted ts_n by AACK_DELAY edges and the retry window
// follows aack by one cycle
module aack_timer import bus_arb_pkg::*; #(
	parameter aack_dly_t AACK_DELAY = 3'd2
) (
	input  logic         clk,
	input  logic         rst_n,
	output logic         aack_n,
	addr_tenure_if.timer tenure
);

	// edges left until aack, zero when no tenure is waiting
	aack_dly_t cnt;
	logic      aack_next;

	// start is already one edge after ts_n, so a delay of one fires at once
	// and longer delays count down from AACK_DELAY-1
	always_comb begin
		aack_next = 1'b0;
		if (tenure.start && AACK_DELAY == 3'd1) begin
			aack_next = 1'b1;
		end else if (cnt == 3'd1) begin
			aack_next = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt           <= '0;
			tenure.aack   <= 1'b0;
			tenure.window <= 1'b0;
			aack_n        <= 1'b1;
		end else begin
			// only one tenure is in its address phase, so start never
			// arrives while the counter is still running
			if (tenure.start) begin
				cnt <= AACK_DELAY - 3'd1;
			end else if (cnt != 3'd0) begin
				cnt <= cnt - 3'd1;
			end
			tenure.aack   <= aack_next;
			aack_n        <= !aack_next;
			tenure.window <= tenure.aack;
		end
	end

endmodule

`default_nettype wire

// File: source/addr_arb_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// address bus arbiter for two masters
// grants alternate between competing requests, a master may park on the bus,
// and no grant is given while a snooper holds artry_n low or the data queue
// is full
module addr_arb_fsm import bus_arb_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          br1_n,
	input  logic          br2_n,
	input  logic          ts_n,
	input  logic          artry_n,
	output logic          bg1_n,
	output logic          bg2_n,
	addr_tenure_if.fsm    tenure
);

	arb_state_e state;
	arb_state_e state_next;
	// high from the accepted ts_n until aack
	logic       active;
	// ts_n is taken as the start of a tenure in this cycle
	logic       accept;
	// master that owns or last owned the address bus
	cpu_id_e    cur_cpu;

	assign cur_cpu = (state == IDLE1 || state == GRANTED1 || state == GRANTED1_AACK) ?
		CPU1 : CPU2;

	always_comb begin
		state_next = state;
		accept     = 1'b0;
		case (state)
			IDLE1, IDLE2: begin
				// a snooper asserting artry_n needs the bus next, and a full
				// queue cannot take another tenure, so hold in both cases
				if (!artry_n || tenure.full) begin
					state_next = state;
				end else if (!ts_n) begin
					// the grant was still held in the window cycle, so this
					// master parked and starts a new tenure without a request
					accept     = 1'b1;
					state_next = (state == IDLE1) ? GRANTED1 : GRANTED2;
				end else if (!br1_n && br2_n) begin
					state_next = GRANTED1;
				end else if (br1_n && !br2_n) begin
					state_next = GRANTED2;
				end else if (br1_n && br2_n) begin
					state_next = state;
				end else begin
					// both request, the master that did not own the bus wins
					state_next = (state == IDLE1) ? GRANTED2 : GRANTED1;
				end
			end
			GRANTED1, GRANTED2: begin
				// only the first ts_n of the grant starts a tenure
				if (!ts_n && !active) begin
					accept = 1'b1;
				end
				if (tenure.aack) begin
					state_next = (state == GRANTED1) ? GRANTED1_AACK : GRANTED2_AACK;
				end
			end
			GRANTED1_AACK: state_next = IDLE1;
			GRANTED2_AACK: state_next = IDLE2;
			default: state_next = IDLE1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= IDLE1;
			active       <= 1'b0;
			tenure.start <= 1'b0;
			bg1_n        <= 1'b1;
			bg2_n        <= 1'b1;
		end else begin
			state        <= state_next;
			tenure.start <= accept;
			if (accept) begin
				active <= 1'b1;
			end else if (tenure.aack) begin
				active <= 1'b0;
			end
			// the grants follow the next state so they change on the same edge
			bg1_n <= !(state_next == GRANTED1 || state_next == GRANTED1_AACK);
			bg2_n <= !(state_next == GRANTED2 || state_next == GRANTED2_AACK);
		end
	end

	// owner travels with start and is only read when start is high
	always_ff @(posedge clk) begin
		if (accept) begin
			tenure.owner <= cur_cpu;
		end
	end

endmodule

`default_nettype wire

// File: source/addr_tenure_if.sv
`timescale 1ns/1ps
`default_nettype none

// events of one address tenure as seen inside the arbiter
// the fsm starts a tenure, the timer acknowledges it and opens the retry
// window, and the queue reports back when it cannot take another entry
interface addr_tenure_if;

	// one-cycle pulse when the fsm accepts ts_n
	logic start;
	// master that owns the tenure, valid with start
	bus_arb_pkg::cpu_id_e owner;
	// one-cycle address acknowledge pulse
	logic aack;
	// retry window, the cycle after aack
	logic window;
	// both queue entries are in use
	logic full;

	modport fsm (output start, output owner, input aack, input full);

	modport timer (input start, output aack, output window);

	modport queue (input start, input owner, input window, output full);

	// the monitor only watches
	modport monitor (input start, input owner, input aack, input window, input full);

endinterface

`default_nettype wire

// File: source/bus_arb_pkg.sv
`default_nettype none

package bus_arb_pkg;

	// address arbiter state
	// IDLEn means the bus is free and master n held it last, which decides
	// who wins when both masters request at once
	// GRANTEDn_AACK covers the retry window, and the grant is still held there
	// so the owner can park on the bus
	typedef enum logic [2:0] {
		IDLE1         = 3'd0,
		IDLE2         = 3'd1,
		GRANTED1      = 3'd2,
		GRANTED1_AACK = 3'd3,
		GRANTED2      = 3'd4,
		GRANTED2_AACK = 3'd5
	} arb_state_e;

	// owner of an address or data tenure
	typedef enum logic {
		CPU1 = 1'b0,
		CPU2 = 1'b1
	} cpu_id_e;

	// type of the address acknowledge delay, 1 to 7 cycles
	typedef logic [2:0] aack_dly_t;

	// type of the data beat count, 1 to 8 beats per data tenure
	typedef logic [3:0] beat_cnt_t;

endpackage

`default_nettype wire
